/* verilog/apmu_pkg.sv */
package apmu_pkg;

  // Field widths
  localparam int unsigned ADDR_WIDTH        = 64;
  localparam int unsigned SRC_ID_WIDTH      = 4;
  localparam int unsigned REGION_IDX_WIDTH  = 1;
  localparam int unsigned EVENT_WIDTH       = 2;
  localparam int unsigned COUNTER_WIDTH     = 16;
  localparam int unsigned COUNTER_IDX_WIDTH = REGION_IDX_WIDTH + EVENT_WIDTH;

  typedef logic [ADDR_WIDTH-1:0]        addr_t;
  typedef logic [SRC_ID_WIDTH-1:0]      src_id_t;
  typedef logic [REGION_IDX_WIDTH-1:0]  region_idx_t;
  // Bit 1 write, bit 0 miss
  typedef logic [EVENT_WIDTH-1:0]       llc_event_t;
  typedef logic [COUNTER_WIDTH-1:0]     counter_t;
  // Region in the upper bit, event code below
  typedef logic [COUNTER_IDX_WIDTH-1:0] counter_idx_t;

  // Event code layout
  localparam int unsigned EVENT_WRITE_BIT = 1;
  localparam int unsigned EVENT_MISS_BIT  = 0;

  // Region indices
  localparam region_idx_t REGION_DEBUG = 1'b0;
  localparam region_idx_t REGION_HYAXI = 1'b1;

  // Address map, both rules half-open
  localparam addr_t DEBUG_BASE   = 64'h0000_0000_0000_0000;
  localparam addr_t HYAXI_BASE   = 64'h0000_0000_8000_0000;
  localparam addr_t HYAXI_LENGTH = 64'h0000_0000_4000_0000;
  localparam addr_t HYAXI_END    = HYAXI_BASE + HYAXI_LENGTH;

  // Counted source IDs, inclusive window
  localparam src_id_t SRC_ID_START = 4'd2;
  localparam src_id_t SRC_ID_END   = 4'd13;

  // Counter bank
  localparam int unsigned NUM_REGIONS = 2;
  localparam int unsigned NUM_EVENTS  = 4;
  localparam int unsigned NUM_COUNTER = NUM_REGIONS * NUM_EVENTS;

  localparam counter_t PMU_IRQ_THRESHOLD = 16'd8;

endpackage

/* verilog/spu_region_match.sv */
`timescale 1ns/1ps

module spu_region_match (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  acc_valid_i,
  input  apmu_pkg::addr_t       acc_addr_i,
  output logic                  region_valid_o,
  output apmu_pkg::region_idx_t region_idx_o
);

  logic                  hit_debug;
  logic                  hit_hyaxi;
  logic                  hit_any;
  apmu_pkg::region_idx_t hit_idx;

  // Rule 0 covers the debug and peripheral space below the HyperRAM window
  always_comb begin
    hit_debug = (acc_addr_i >= apmu_pkg::DEBUG_BASE) &&
                (acc_addr_i <  apmu_pkg::HYAXI_BASE);
  end

  // Rule 1 is the HyperRAM window
  always_comb begin
    hit_hyaxi = (acc_addr_i >= apmu_pkg::HYAXI_BASE) &&
                (acc_addr_i <  apmu_pkg::HYAXI_END);
  end

  // Rules are disjoint, so the order only matters for the encoding
  always_comb begin
    hit_any = hit_debug || hit_hyaxi;
    if (hit_hyaxi) begin
      hit_idx = apmu_pkg::REGION_HYAXI;
    end else begin
      hit_idx = apmu_pkg::REGION_DEBUG;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      region_valid_o <= 1'b0;
    end else begin
      region_valid_o <= acc_valid_i && hit_any;
    end
  end

  // Index only meaningful alongside the strobe
  always_ff @(posedge clk_i) begin
    if (acc_valid_i && hit_any) begin
      region_idx_o <= hit_idx;
    end
  end

endmodule

/* verilog/llc_event_filter.sv */
`timescale 1ns/1ps

module llc_event_filter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 acc_valid_i,
  input  apmu_pkg::src_id_t    acc_id_i,
  input  logic                 acc_write_i,
  input  logic                 acc_hit_i,
  output logic                 event_valid_o,
  output apmu_pkg::llc_event_t event_code_o
);

  logic                 id_in_window;
  apmu_pkg::llc_event_t code;

  // Same source ID window as the cache, both ends counted
  always_comb begin
    id_in_window = (acc_id_i >= apmu_pkg::SRC_ID_START) &&
                   (acc_id_i <= apmu_pkg::SRC_ID_END);
  end

  always_comb begin
    code = '0;
    code[apmu_pkg::EVENT_WRITE_BIT] = acc_write_i;
    code[apmu_pkg::EVENT_MISS_BIT]  = ~acc_hit_i;
  end

  // One cycle, lines up with the region classifier
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      event_valid_o <= 1'b0;
    end else begin
      event_valid_o <= acc_valid_i && id_in_window;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_valid_i && id_in_window) begin
      event_code_o <= code;
    end
  end

endmodule

/* verilog/pmu_counter_bank.sv */
`timescale 1ns/1ps

module pmu_counter_bank (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               region_valid_i,
  input  apmu_pkg::region_idx_t              region_idx_i,
  input  logic                               event_valid_i,
  input  apmu_pkg::llc_event_t               event_code_i,
  input  logic                               rd_valid_i,
  input  apmu_pkg::counter_idx_t             rd_idx_i,
  output logic                               rd_valid_o,
  output apmu_pkg::counter_t                 rd_data_o,
  output logic [apmu_pkg::NUM_COUNTER-1:0]   irq_o
);

  apmu_pkg::counter_t                 cnt_q [apmu_pkg::NUM_COUNTER];
  apmu_pkg::counter_t                 cnt_next [apmu_pkg::NUM_COUNTER];
  apmu_pkg::counter_idx_t             inc_idx;
  logic                               inc_en;
  logic [apmu_pkg::NUM_COUNTER-1:0]   inc_hit;
  logic [apmu_pkg::NUM_COUNTER-1:0]   rd_hit;

  // Count only when address and source ID both qualify
  assign inc_en  = region_valid_i && event_valid_i;
  assign inc_idx = {region_idx_i, event_code_i};

  always_comb begin
    for (int k = 0; k < apmu_pkg::NUM_COUNTER; k++) begin
      inc_hit[k]  = inc_en && (inc_idx == apmu_pkg::counter_idx_t'(k));
      rd_hit[k]   = rd_valid_i && (rd_idx_i == apmu_pkg::counter_idx_t'(k));
      cnt_next[k] = cnt_q[k] + apmu_pkg::counter_t'(1);
    end
  end

  // Counters wrap at the counter width
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int k = 0; k < apmu_pkg::NUM_COUNTER; k++) begin
        cnt_q[k] <= '0;
      end
      irq_o <= '0;
    end else begin
      for (int k = 0; k < apmu_pkg::NUM_COUNTER; k++) begin
        if (rd_hit[k]) begin
          // Read clears, a coinciding increment restarts at one
          if (inc_hit[k]) begin
            cnt_q[k] <= apmu_pkg::counter_t'(1);
          end else begin
            cnt_q[k] <= '0;
          end
          irq_o[k] <= 1'b0;
        end else if (inc_hit[k]) begin
          cnt_q[k] <= cnt_next[k];
          // Sticky until the counter is read
          if (cnt_next[k] == apmu_pkg::PMU_IRQ_THRESHOLD) begin
            irq_o[k] <= 1'b1;
          end
        end
      end
    end
  end

  // Read port sees the value before this edge's update
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      rd_data_o <= cnt_q[rd_idx_i];
    end
  end

endmodule

/* verilog/apmu_top.sv */
`timescale 1ns/1ps

module apmu_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               acc_valid_i,
  input  apmu_pkg::addr_t                    acc_addr_i,
  input  apmu_pkg::src_id_t                  acc_id_i,
  input  logic                               acc_write_i,
  input  logic                               acc_hit_i,
  input  logic                               rd_valid_i,
  input  apmu_pkg::counter_idx_t             rd_idx_i,
  output logic                               rd_valid_o,
  output apmu_pkg::counter_t                 rd_data_o,
  output logic [apmu_pkg::NUM_COUNTER-1:0]   irq_o
);

  logic                  region_valid;
  apmu_pkg::region_idx_t region_idx;
  logic                  event_valid;
  apmu_pkg::llc_event_t  event_code;

  // Address side, SPU rules
  spu_region_match i_region_match (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .acc_valid_i    ( acc_valid_i  ),
    .acc_addr_i     ( acc_addr_i   ),
    .region_valid_o ( region_valid ),
    .region_idx_o   ( region_idx   )
  );

  // Cache side, source ID window and hit or miss kind
  llc_event_filter i_event_filter (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .acc_valid_i   ( acc_valid_i ),
    .acc_id_i      ( acc_id_i    ),
    .acc_write_i   ( acc_write_i ),
    .acc_hit_i     ( acc_hit_i   ),
    .event_valid_o ( event_valid ),
    .event_code_o  ( event_code  )
  );

  pmu_counter_bank i_counter_bank (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .region_valid_i ( region_valid ),
    .region_idx_i   ( region_idx   ),
    .event_valid_i  ( event_valid  ),
    .event_code_i   ( event_code   ),
    .rd_valid_i     ( rd_valid_i   ),
    .rd_idx_i       ( rd_idx_i     ),
    .rd_valid_o     ( rd_valid_o   ),
    .rd_data_o      ( rd_data_o    ),
    .irq_o          ( irq_o        )
  );

endmodule

/* dv/apmu_top_sva.sv */
`timescale 1ns/1ps

module apmu_top_sva (
  input logic                               clk_i,
  input logic                               rst_i,
  input logic                               rd_valid_i,
  input logic                               rd_valid_o,
  input apmu_pkg::counter_t                 rd_data_o,
  input logic [apmu_pkg::NUM_COUNTER-1:0]   irq_o
);

  // Gates $past until one edge has been seen
  logic past_valid = 1'b0;

  always @(posedge clk_i) begin
    past_valid <= 1'b1;
  end

  // Read response one cycle after the strobe, zero after reset
  a_rd_valid_latency: assert property (
    @(posedge clk_i) past_valid |->
      rd_valid_o == ($past(rst_i) ? 1'b0 : $past(rd_valid_i))
  ) else $error("rd_valid_o does not follow rd_valid_i by one cycle");

  a_irq_clear_after_reset: assert property (
    @(posedge clk_i) past_valid && $past(rst_i) |-> irq_o == '0
  ) else $error("irq_o is not zero in the cycle after reset");

  a_rd_data_known: assert property (
    @(posedge clk_i) rd_valid_o |-> !$isunknown(rd_data_o)
  ) else $error("rd_data_o is unknown while rd_valid_o is high");

endmodule

bind apmu_top apmu_top_sva i_sva (
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .rd_valid_i ( rd_valid_i ),
  .rd_valid_o ( rd_valid_o ),
  .rd_data_o  ( rd_data_o  ),
  .irq_o      ( irq_o      )
);

/* dv/tb_apmu_top.sv */
`timescale 1ns/1ps

module tb_apmu_top;

  localparam int RAND_ACCESSES    = 200;
  localparam int OUTSIDE_ACCESSES = 32;
  localparam int MIX_STEPS        = 600;
  localparam int IRQ_COUNTER      = 5;
  localparam int COLLIDE_COUNTER  = 6;
  // Idle pair plus the read strobe
  localparam int READ_CYCLES      = 3;
  // Upper bound on reads over all tests
  localparam int MAX_READS        = 8 * 5 + 4 + MIX_STEPS;
  localparam int STIM_CYCLES      = MAX_READS * READ_CYCLES + RAND_ACCESSES +
                                    OUTSIDE_ACCESSES + MIX_STEPS + 64;
  localparam int TIMEOUT_CYCLES   = STIM_CYCLES + 500;

  logic                               clk_i;
  logic                               rst_i;
  logic                               acc_valid_i;
  apmu_pkg::addr_t                    acc_addr_i;
  apmu_pkg::src_id_t                  acc_id_i;
  logic                               acc_write_i;
  logic                               acc_hit_i;
  logic                               rd_valid_i;
  apmu_pkg::counter_idx_t             rd_idx_i;
  logic                               rd_valid_o;
  apmu_pkg::counter_t                 rd_data_o;
  logic [apmu_pkg::NUM_COUNTER-1:0]   irq_o;

  // Expected state
  apmu_pkg::counter_t                 exp_cnt [apmu_pkg::NUM_COUNTER];
  logic [apmu_pkg::NUM_COUNTER-1:0]   exp_irq;
  apmu_pkg::counter_t                 exp_q [$];
  string                              name_q [$];

  logic [31:0]       lcg_state;
  string             test_name;
  int                check_count;
  int                error_count;
  int                errors_at_start;
  int                checks_at_start;
  apmu_pkg::src_id_t bad_ids [4] = '{4'd0, 4'd1, 4'd14, 4'd15};

  apmu_top i_dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .acc_valid_i ( acc_valid_i ),
    .acc_addr_i  ( acc_addr_i  ),
    .acc_id_i    ( acc_id_i    ),
    .acc_write_i ( acc_write_i ),
    .acc_hit_i   ( acc_hit_i   ),
    .rd_valid_i  ( rd_valid_i  ),
    .rd_idx_i    ( rd_idx_i    ),
    .rd_valid_o  ( rd_valid_o  ),
    .rd_data_o   ( rd_data_o   ),
    .irq_o       ( irq_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits only since the low LCG bits repeat quickly
  function automatic int unsigned rand_below(int unsigned n);
    return (lcg_next() >> 8) % n;
  endfunction

  // Kind 0 and 1 pick a region and kind 2 lands above both
  function automatic apmu_pkg::addr_t random_addr(int kind);
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = lcg_next();
    r1 = lcg_next();
    case (kind)
      0: return apmu_pkg::DEBUG_BASE +
                (apmu_pkg::addr_t'(r0) % (apmu_pkg::HYAXI_BASE - apmu_pkg::DEBUG_BASE));
      1: return apmu_pkg::HYAXI_BASE + (apmu_pkg::addr_t'(r0) % apmu_pkg::HYAXI_LENGTH);
      default: return apmu_pkg::HYAXI_BASE + apmu_pkg::HYAXI_LENGTH + {2'b00, r1[29:0], r0};
    endcase
  endfunction

  // Counter index of an access or -1 when it is not counted
  function automatic int expected_index(apmu_pkg::addr_t addr, apmu_pkg::src_id_t id,
                                        logic write, logic hit);
    int region;
    region = -1;
    if (addr >= apmu_pkg::DEBUG_BASE && addr < apmu_pkg::HYAXI_BASE) begin
      region = 0;
    end else if (addr >= apmu_pkg::HYAXI_BASE &&
                 addr < apmu_pkg::HYAXI_BASE + apmu_pkg::HYAXI_LENGTH) begin
      region = 1;
    end
    if (region < 0 || id < apmu_pkg::SRC_ID_START || id > apmu_pkg::SRC_ID_END) begin
      return -1;
    end
    return region * 4 + (write ? 2 : 0) + (hit ? 0 : 1);
  endfunction

  function automatic void model_update(int idx);
    if (idx >= 0) begin
      exp_cnt[idx] = exp_cnt[idx] + apmu_pkg::counter_t'(1);
      if (exp_cnt[idx] == apmu_pkg::PMU_IRQ_THRESHOLD) begin
        exp_irq[idx] = 1'b1;
      end
    end
  endfunction

  task automatic compare_value(string name, logic [63:0] expected, logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("mismatch %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk_i);
      acc_valid_i <= 1'b0;
      rd_valid_i  <= 1'b0;
    end
  endtask

  task automatic drive_access(apmu_pkg::addr_t addr, apmu_pkg::src_id_t id,
                              logic write, logic hit);
    @(posedge clk_i);
    acc_valid_i <= 1'b1;
    acc_addr_i  <= addr;
    acc_id_i    <= id;
    acc_write_i <= write;
    acc_hit_i   <= hit;
    rd_valid_i  <= 1'b0;
  endtask

  task automatic send_access(apmu_pkg::addr_t addr, apmu_pkg::src_id_t id,
                             logic write, logic hit);
    drive_access(addr, id, write, hit);
    model_update(expected_index(addr, id, write, hit));
  endtask

  // Fields of an in-window access that lands in counter k
  task automatic make_access(input int k, output apmu_pkg::addr_t addr,
                             output apmu_pkg::src_id_t id, output logic write,
                             output logic hit);
    addr  = random_addr(k / 4);
    id    = apmu_pkg::SRC_ID_START + apmu_pkg::src_id_t'(rand_below(
              apmu_pkg::SRC_ID_END - apmu_pkg::SRC_ID_START + 1));
    write = ((k / 2) % 2) != 0;
    hit   = (k % 2) == 0;
  endtask

  task automatic send_to_counter(int k);
    apmu_pkg::addr_t   addr;
    apmu_pkg::src_id_t id;
    logic              write;
    logic              hit;
    make_access(k, addr, id, write, hit);
    send_access(addr, id, write, hit);
  endtask

  task automatic issue_read(int idx, apmu_pkg::counter_t expected);
    @(posedge clk_i);
    acc_valid_i <= 1'b0;
    rd_valid_i  <= 1'b1;
    rd_idx_i    <= apmu_pkg::counter_idx_t'(idx);
    exp_q.push_back(expected);
    name_q.push_back(test_name);
  endtask

  // Settle, check the interrupts, then read and clear
  task automatic read_counter(int idx);
    apmu_pkg::counter_t expected;
    idle_cycles(2);
    @(negedge clk_i);
    compare_value({test_name, " irq"}, exp_irq, irq_o);
    expected     = exp_cnt[idx];
    exp_cnt[idx] = '0;
    exp_irq[idx] = 1'b0;
    issue_read(idx, expected);
  endtask

  task automatic read_all();
    for (int k = 0; k < apmu_pkg::NUM_COUNTER; k++) begin
      read_counter(k);
    end
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 4) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      error_count++;
      $display("error %s: a read response never arrived", test_name);
      exp_q.delete();
      name_q.delete();
    end
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = error_count;
    checks_at_start = check_count;
  endtask

  task automatic finish_test();
    idle_cycles(1);
    drain_reads();
    $display("test %s done: %0d checks, %0d errors", test_name,
             check_count - checks_at_start, error_count - errors_at_start);
  endtask

  // Every read response is compared against the queued expectation
  always @(negedge clk_i) begin
    if (rd_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("error: read response arrived with no read pending");
      end else begin
        compare_value(name_q.pop_front(), exp_q.pop_front(), rd_data_o);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    apmu_pkg::addr_t    addr;
    apmu_pkg::src_id_t  id;
    logic               write;
    logic               hit;
    apmu_pkg::counter_t old_val;

    lcg_state   = 32'hc43d_2aea;
    check_count = 0;
    error_count = 0;
    exp_irq     = '0;
    for (int k = 0; k < apmu_pkg::NUM_COUNTER; k++) begin
      exp_cnt[k] = '0;
    end
    rst_i       = 1'b1;
    acc_valid_i = 1'b0;
    acc_addr_i  = '0;
    acc_id_i    = '0;
    acc_write_i = 1'b0;
    acc_hit_i   = 1'b0;
    rd_valid_i  = 1'b0;
    rd_idx_i    = '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    start_test("reset_state");
    @(negedge clk_i);
    compare_value(test_name, '0, irq_o);
    read_all();
    finish_test();

    start_test("region_events");
    for (int i = 0; i < RAND_ACCESSES; i++) begin
      addr  = random_addr(rand_below(2));
      id    = apmu_pkg::SRC_ID_START + apmu_pkg::src_id_t'(rand_below(
                apmu_pkg::SRC_ID_END - apmu_pkg::SRC_ID_START + 1));
      write = rand_below(2) != 0;
      hit   = rand_below(2) != 0;
      send_access(addr, id, write, hit);
    end
    read_all();
    finish_test();

    // Out of window IDs and addresses above both regions
    start_test("filtered_out");
    for (int i = 0; i < OUTSIDE_ACCESSES; i++) begin
      if (i % 2 == 0) begin
        addr = random_addr(rand_below(2));
        id   = bad_ids[(i / 2) % 4];
      end else begin
        addr = random_addr(2);
        id   = apmu_pkg::SRC_ID_START + apmu_pkg::src_id_t'(rand_below(
                 apmu_pkg::SRC_ID_END - apmu_pkg::SRC_ID_START + 1));
      end
      write = rand_below(2) != 0;
      hit   = rand_below(2) != 0;
      send_access(addr, id, write, hit);
    end
    read_all();
    finish_test();

    start_test("irq_threshold");
    for (int i = 0; i < int'(apmu_pkg::PMU_IRQ_THRESHOLD); i++) begin
      send_to_counter(IRQ_COUNTER);
    end
    idle_cycles(2);
    @(negedge clk_i);
    compare_value(test_name, 64'd1 << IRQ_COUNTER, irq_o);
    read_counter(IRQ_COUNTER);
    idle_cycles(2);
    @(negedge clk_i);
    compare_value(test_name, '0, irq_o);
    read_counter(IRQ_COUNTER);
    finish_test();

    // Read lands on the same edge as the increment, with the interrupt already set
    start_test("read_on_increment");
    repeat (int'(apmu_pkg::PMU_IRQ_THRESHOLD)) send_to_counter(COLLIDE_COUNTER);
    idle_cycles(2);
    old_val = exp_cnt[COLLIDE_COUNTER];
    make_access(COLLIDE_COUNTER, addr, id, write, hit);
    drive_access(addr, id, write, hit);
    issue_read(COLLIDE_COUNTER, old_val);
    exp_cnt[COLLIDE_COUNTER] = apmu_pkg::counter_t'(1);
    exp_irq[COLLIDE_COUNTER] = 1'b0;
    read_counter(COLLIDE_COUNTER);
    finish_test();

    start_test("random_mix");
    for (int s = 0; s < MIX_STEPS; s++) begin
      if (rand_below(8) == 0) begin
        read_counter(rand_below(apmu_pkg::NUM_COUNTER));
      end else begin
        addr  = random_addr(rand_below(3));
        id    = apmu_pkg::src_id_t'(rand_below(16));
        write = rand_below(2) != 0;
        hit   = rand_below(2) != 0;
        send_access(addr, id, write, hit);
      end
    end
    read_all();
    finish_test();

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/apmu_pkg.sv
verilog/spu_region_match.sv
verilog/llc_event_filter.sv
verilog/pmu_counter_bank.sv
verilog/apmu_top.sv
dv/apmu_top_sva.sv
dv/tb_apmu_top.sv

/* Bender.yml */
package:
  name: apmu

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - verilog/apmu_pkg.sv
      - verilog/spu_region_match.sv
      - verilog/llc_event_filter.sv
      - verilog/pmu_counter_bank.sv
      - verilog/apmu_top.sv

  - target: test
    files:
      - dv/apmu_top_sva.sv
      - dv/tb_apmu_top.sv
